// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= evr_core_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/evr_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module evr_core
    import evr_pkg::*;
(
    input  logic               rx_clk,
    input  logic               app_rst,

    input  logic               aligned_i,
    input  logic [2*SYM_W-1:0] rx_data_i,
    input  logic [1:0]         rx_charisk_i,

    input  mmr_addr_t          mmr_araddr_i,
    input  logic               mmr_arvalid_i,
    output logic               mmr_arready_o,
    output mmr_data_t          mmr_rdata_o,
    output logic [1:0]         mmr_rresp_o,
    output logic               mmr_rvalid_o,
    input  logic               mmr_rready_i,
    input  mmr_addr_t          mmr_awaddr_i,
    input  logic               mmr_awvalid_i,
    output logic               mmr_awready_o,
    input  mmr_data_t          mmr_wdata_i,
    input  logic               mmr_wvalid_i,
    output logic               mmr_wready_o,
    output logic [1:0]         mmr_bresp_o,
    output logic               mmr_bvalid_o,
    input  logic               mmr_bready_i,

    output ev_code_t           ev_o
);

    logic         beacon;
    sym_byte_t    sh_byte;
    logic         sh_isk;
    logic         sh_valid;
    logic         ev_ena;
    mmr_data_t    link_delay;
    mmr_data_t    topo_id;
    link_status_t link_status;
    mmr_data_t    beacon_cnt;

    evr_symbol_decode decode_i (
        .rx_clk       (rx_clk),
        .app_rst      (app_rst),
        .aligned_i    (aligned_i),
        .rx_data_i    (rx_data_i),
        .rx_charisk_i (rx_charisk_i),
        .ev_ena_i     (ev_ena),
        .ev_o         (ev_o),
        .beacon_o     (beacon),
        .sh_byte_o    (sh_byte),
        .sh_isk_o     (sh_isk),
        .sh_valid_o   (sh_valid)
    );

    evr_link_parser parser_i (
        .rx_clk        (rx_clk),
        .app_rst       (app_rst),
        .sh_byte_i     (sh_byte),
        .sh_isk_i      (sh_isk),
        .sh_valid_i    (sh_valid),
        .beacon_i      (beacon),
        .link_delay_o  (link_delay),
        .topo_id_o     (topo_id),
        .link_status_o (link_status),
        .beacon_cnt_o  (beacon_cnt)
    );

    evr_mmr_regs regs_i (
        .rx_clk        (rx_clk),
        .app_rst       (app_rst),
        .aligned_i     (aligned_i),
        .mmr_araddr_i  (mmr_araddr_i),
        .mmr_arvalid_i (mmr_arvalid_i),
        .mmr_arready_o (mmr_arready_o),
        .mmr_rdata_o   (mmr_rdata_o),
        .mmr_rresp_o   (mmr_rresp_o),
        .mmr_rvalid_o  (mmr_rvalid_o),
        .mmr_rready_i  (mmr_rready_i),
        .mmr_awaddr_i  (mmr_awaddr_i),
        .mmr_awvalid_i (mmr_awvalid_i),
        .mmr_awready_o (mmr_awready_o),
        .mmr_wdata_i   (mmr_wdata_i),
        .mmr_wvalid_i  (mmr_wvalid_i),
        .mmr_wready_o  (mmr_wready_o),
        .mmr_bresp_o   (mmr_bresp_o),
        .mmr_bvalid_o  (mmr_bvalid_o),
        .mmr_bready_i  (mmr_bready_i),
        .link_delay_i  (link_delay),
        .topo_id_i     (topo_id),
        .link_status_i (link_status),
        .beacon_cnt_i  (beacon_cnt),
        .ev_ena_o      (ev_ena)
    );

endmodule

`default_nettype wire

// ==== logic/evr_link_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module evr_link_parser
    import evr_pkg::*;
(
    input  logic         rx_clk,
    input  logic         app_rst,

    input  sym_byte_t    sh_byte_i,
    input  logic         sh_isk_i,
    input  logic         sh_valid_i,

    input  logic         beacon_i,

    output mmr_data_t    link_delay_o,
    output mmr_data_t    topo_id_o,
    output link_status_t link_status_o,
    output mmr_data_t    beacon_cnt_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_TYPE,
        ST_PAYLOAD
    } state_t;

    state_t                       state;
    logic [BYTE_CNT_W-1:0]        byte_cnt;
    sym_byte_t                    msg_type;
    logic [MMR_DATA_W-SYM_W-1:0]  pay_sr;

    logic      is_start;
    logic      last_byte;
    mmr_data_t payload;

    assign is_start  = sh_isk_i && (sh_byte_i == FRAME_START_SYM);
    assign last_byte = byte_cnt == BYTE_CNT_W'(PAYLOAD_BYTES - 1);

    // Final byte completes the word, MSB first
    assign payload = {pay_sr, sh_byte_i};

    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            state         <= ST_IDLE;
            byte_cnt      <= '0;
            link_delay_o  <= '0;
            topo_id_o     <= '0;
            link_status_o <= '0;
            beacon_cnt_o  <= '0;
        end
        else begin
            if (beacon_i) begin
                beacon_cnt_o <= beacon_cnt_o + mmr_data_t'(1);
            end

            if (!sh_valid_i) begin
                state <= ST_IDLE;
            end
            else if (state != ST_IDLE && sh_isk_i) begin
                // K symbol inside a frame, a start marker restarts at once
                link_status_o.frame_abort <= 1'b1;
                state <= is_start ? ST_TYPE : ST_IDLE;
            end
            else begin
                case (state)
                    ST_IDLE: begin
                        if (is_start) begin
                            state <= ST_TYPE;
                        end
                    end
                    ST_TYPE: begin
                        byte_cnt <= '0;
                        state    <= ST_PAYLOAD;
                    end
                    ST_PAYLOAD: begin
                        byte_cnt <= byte_cnt + BYTE_CNT_W'(1);
                        if (last_byte) begin
                            state <= ST_IDLE;
                            case (msg_type)
                                MSG_DELAY: begin
                                    link_delay_o             <= payload;
                                    link_status_o.delay_seen <= 1'b1;
                                end
                                MSG_TOPO: begin
                                    topo_id_o               <= payload;
                                    link_status_o.topo_seen <= 1'b1;
                                end
                                // Unknown type, frame dropped
                                default: ;
                            endcase
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // Frame contents
    always_ff @(posedge rx_clk) begin
        if (sh_valid_i && !sh_isk_i) begin
            if (state == ST_TYPE) begin
                msg_type <= sh_byte_i;
            end
            if (state == ST_PAYLOAD) begin
                pay_sr <= {pay_sr[MMR_DATA_W-2*SYM_W-1:0], sh_byte_i};
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/evr_mmr_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module evr_mmr_regs
    import evr_pkg::*;
(
    input  logic         rx_clk,
    input  logic         app_rst,

    input  logic         aligned_i,

    // AXI4-Lite read channels
    input  mmr_addr_t    mmr_araddr_i,
    input  logic         mmr_arvalid_i,
    output logic         mmr_arready_o,
    output mmr_data_t    mmr_rdata_o,
    output logic [1:0]   mmr_rresp_o,
    output logic         mmr_rvalid_o,
    input  logic         mmr_rready_i,

    // AXI4-Lite write channels
    input  mmr_addr_t    mmr_awaddr_i,
    input  logic         mmr_awvalid_i,
    output logic         mmr_awready_o,
    input  mmr_data_t    mmr_wdata_i,
    input  logic         mmr_wvalid_i,
    output logic         mmr_wready_o,
    output logic [1:0]   mmr_bresp_o,
    output logic         mmr_bvalid_o,
    input  logic         mmr_bready_i,

    input  mmr_data_t    link_delay_i,
    input  mmr_data_t    topo_id_i,
    input  link_status_t link_status_i,
    input  mmr_data_t    beacon_cnt_i,

    output logic         ev_ena_o
);

    logic      rd_busy;
    mmr_addr_t rd_addr;
    mmr_data_t rd_mux;

    logic      aw_done;
    logic      w_done;
    mmr_addr_t wr_addr;
    mmr_data_t wr_data;

    mmr_data_t tgt_delay;
    logic      ev_ena;

    assign mmr_rresp_o = AXI_RESP_OKAY;
    assign mmr_bresp_o = AXI_RESP_OKAY;
    assign ev_ena_o    = ev_ena;

    always_comb begin
        case (rd_addr)
            REG_SR:         rd_mux = mmr_data_t'({link_status_i, aligned_i});
            REG_CR:         rd_mux = mmr_data_t'(ev_ena);
            REG_TOPO_ID:    rd_mux = topo_id_i;
            REG_LINK_DELAY: rd_mux = link_delay_i;
            REG_TGT_DELAY:  rd_mux = tgt_delay;
            REG_DELAY_DIFF: rd_mux = tgt_delay - link_delay_i;
            REG_BEACON_CNT: rd_mux = beacon_cnt_i;
            default:        rd_mux = '0;
        endcase
    end

    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            mmr_arready_o <= 1'b0;
            mmr_rvalid_o  <= 1'b0;
            mmr_awready_o <= 1'b0;
            mmr_wready_o  <= 1'b0;
            mmr_bvalid_o  <= 1'b0;
            rd_busy       <= 1'b0;
            aw_done       <= 1'b0;
            w_done        <= 1'b0;
            tgt_delay     <= '0;
            ev_ena        <= 1'b0;
        end
        else begin
            // Read side, one access in flight
            mmr_arready_o <= 1'b0;
            if (mmr_arvalid_i && !rd_busy) begin
                rd_addr       <= mmr_araddr_i;
                rd_busy       <= 1'b1;
                mmr_arready_o <= 1'b1;
            end

            if (rd_busy && !mmr_rvalid_o) begin
                mmr_rvalid_o <= 1'b1;
                mmr_rdata_o  <= rd_mux;
            end

            if (mmr_rvalid_o && mmr_rready_i) begin
                mmr_rvalid_o <= 1'b0;
                rd_busy      <= 1'b0;
            end

            // Write side, AW and W captured independently
            mmr_awready_o <= 1'b0;
            if (mmr_awvalid_i && !aw_done) begin
                wr_addr       <= mmr_awaddr_i;
                aw_done       <= 1'b1;
                mmr_awready_o <= 1'b1;
            end

            mmr_wready_o <= 1'b0;
            if (mmr_wvalid_i && !w_done) begin
                wr_data      <= mmr_wdata_i;
                w_done       <= 1'b1;
                mmr_wready_o <= 1'b1;
            end

            if (aw_done && w_done && !mmr_bvalid_o) begin
                mmr_bvalid_o <= 1'b1;
            end

            if (mmr_bvalid_o && mmr_bready_i) begin
                mmr_bvalid_o <= 1'b0;
                aw_done      <= 1'b0;
                w_done       <= 1'b0;
                case (wr_addr)
                    REG_CR:   ev_ena <= wr_data[0];
                    REG_CR_S: ev_ena <= ev_ena | wr_data[0];
                    REG_CR_C: ev_ena <= ev_ena & ~wr_data[0];
                    REG_TGT_DELAY: begin
                        // Target must lie beyond the measured delay
                        if (wr_data > link_delay_i) begin
                            tgt_delay <= wr_data;
                        end
                    end
                    default: ;
                endcase
            end

            // No events without a link
            if (!aligned_i) begin
                ev_ena <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/evr_pkg.sv ====
`default_nettype none

package evr_pkg;

    localparam int SYM_W         = 8;
    localparam int EV_W          = 8;
    localparam int MMR_ADDR_W    = 8;
    localparam int MMR_DATA_W    = 32;
    localparam int PAYLOAD_BYTES = 4;
    localparam int BYTE_CNT_W    = $clog2(PAYLOAD_BYTES);

    typedef logic [SYM_W-1:0]      sym_byte_t;
    typedef logic [EV_W-1:0]       ev_code_t;
    typedef logic [MMR_ADDR_W-1:0] mmr_addr_t;
    typedef logic [MMR_DATA_W-1:0] mmr_data_t;

    // Sticky link flags, reported in SR bits 3 to 1
    typedef struct packed {
        logic delay_seen;
        logic topo_seen;
        logic frame_abort;
    } link_status_t;

    // Symbols, K flag noted per symbol
    localparam sym_byte_t BEACON_SYM      = 8'h7E;
    localparam sym_byte_t COMMA_SYM       = 8'hBC;
    localparam sym_byte_t FRAME_START_SYM = 8'h1C;

    // Shared-data message types
    localparam sym_byte_t MSG_DELAY = 8'h01;
    localparam sym_byte_t MSG_TOPO  = 8'h02;

    // Register map
    localparam mmr_addr_t REG_SR         = 8'h00;
    localparam mmr_addr_t REG_CR         = 8'h04;
    localparam mmr_addr_t REG_CR_S       = 8'h08;
    localparam mmr_addr_t REG_CR_C       = 8'h0C;
    localparam mmr_addr_t REG_TOPO_ID    = 8'h10;
    localparam mmr_addr_t REG_LINK_DELAY = 8'h14;
    localparam mmr_addr_t REG_TGT_DELAY  = 8'h18;
    localparam mmr_addr_t REG_DELAY_DIFF = 8'h1C;
    localparam mmr_addr_t REG_BEACON_CNT = 8'h20;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== logic/evr_symbol_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module evr_symbol_decode
    import evr_pkg::*;
(
    input  logic                 rx_clk,
    input  logic                 app_rst,

    input  logic                 aligned_i,
    input  logic [2*SYM_W-1:0]   rx_data_i,
    input  logic [1:0]           rx_charisk_i,

    input  logic                 ev_ena_i,

    output ev_code_t             ev_o,
    output logic                 beacon_o,

    output sym_byte_t            sh_byte_o,
    output logic                 sh_isk_o,
    output logic                 sh_valid_o
);

    sym_byte_t lo_byte;
    logic      lo_isk;
    logic      lo_beacon;
    logic      lo_event;

    // Low lane carries events and beacons
    assign lo_byte = rx_data_i[SYM_W-1:0];
    assign lo_isk  = rx_charisk_i[0];

    assign lo_beacon = !lo_isk && (lo_byte == BEACON_SYM);

    // Zero is the null code, K symbols are never events
    assign lo_event = ev_ena_i
                   && !lo_isk
                   && (lo_byte != '0)
                   && (lo_byte != BEACON_SYM);

    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            ev_o       <= '0;
            beacon_o   <= 1'b0;
            sh_valid_o <= 1'b0;
        end
        else begin
            ev_o       <= '0;
            beacon_o   <= 1'b0;
            sh_valid_o <= aligned_i;

            if (aligned_i) begin
                beacon_o <= lo_beacon;
                if (lo_event) begin
                    ev_o <= ev_code_t'(lo_byte);
                end
            end
        end
    end

    // High lane goes to the parser as is
    always_ff @(posedge rx_clk) begin
        if (aligned_i) begin
            sh_byte_o <= rx_data_i[2*SYM_W-1:SYM_W];
            sh_isk_o  <= rx_charisk_i[1];
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/evr_pkg.sv
logic/evr_symbol_decode.sv
logic/evr_link_parser.sv
logic/evr_mmr_regs.sv
logic/evr_core.sv
test/evr_core_tb.sv

// ==== test/evr_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module evr_core_tb
    import evr_pkg::*;
();

    localparam int N_RAND_EV   = 200;
    localparam int N_RAND_ENA  = 300;
    localparam int N_RAND_TAIL = 50;
    localparam int N_RAND_DOWN = 40;
    localparam int N_BEACON    = 25;
    localparam int N_AXI       = 20;
    localparam int AXI_MARGIN  = 12;
    localparam int N_WORDS     = N_RAND_EV + N_RAND_ENA + N_RAND_TAIL + 2 * N_BEACON
                               + 3 * 8 + 2 * N_RAND_DOWN + 20;
    localparam int CYCLE_LIMIT = N_WORDS + N_AXI * AXI_MARGIN + 100;
    localparam mmr_data_t TGT_MARGIN = 32'h0000_0400;

    logic         rx_clk = 1'b0;
    logic         app_rst;
    logic         aligned_i;
    logic [15:0]  rx_data_i;
    logic [1:0]   rx_charisk_i;
    mmr_addr_t    mmr_araddr_i;
    logic         mmr_arvalid_i;
    logic         mmr_arready_o;
    mmr_data_t    mmr_rdata_o;
    logic [1:0]   mmr_rresp_o;
    logic         mmr_rvalid_o;
    logic         mmr_rready_i;
    mmr_addr_t    mmr_awaddr_i;
    logic         mmr_awvalid_i;
    logic         mmr_awready_o;
    mmr_data_t    mmr_wdata_i;
    logic         mmr_wvalid_i;
    logic         mmr_wready_o;
    logic [1:0]   mmr_bresp_o;
    logic         mmr_bvalid_o;
    logic         mmr_bready_i;
    ev_code_t     ev_o;

    integer       seed;
    int           cycles = 0;
    int           ev_errs = 0;
    int           reg_errs = 0;
    int           resp_errs = 0;
    logic         run_checks = 1'b0;
    ev_code_t     ev_exp = '0;
    logic         ena_model = 1'b0;
    logic         link_model = 1'b1;
    link_status_t status_m = '0;
    mmr_data_t    delay_model = '0;
    mmr_data_t    topo_model = '0;
    mmr_data_t    tgt_model = '0;
    mmr_data_t    beacon_model = '0;
    mmr_data_t    rd_val;

    evr_core evr_core_i (.*);

    always #5 rx_clk = ~rx_clk;

    always @(posedge rx_clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Decode rule for the low lane
    function automatic ev_code_t expected_ev(input logic [15:0] data, input logic [1:0] isk,
                                             input logic ena, input logic link_up);
        sym_byte_t lo;
        lo = data[7:0];
        if (!link_up || !ena || isk[0] || lo == 8'h00 || lo == BEACON_SYM) begin
            return '0;
        end
        return lo;
    endfunction

    function automatic mmr_data_t expected_sr();
        return mmr_data_t'({status_m, link_model});
    endfunction

    task automatic check_ev(input ev_code_t got, input ev_code_t exp);
        if (got !== exp) begin
            ev_errs++;
            $display("error: ev_o is %h, expected %h in cycle %0d", got, exp, cycles);
        end
    endtask

    task automatic check_reg(input string name, input mmr_data_t got, input mmr_data_t exp);
        if (got !== exp) begin
            reg_errs++;
            $display("error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got);
        if (got !== AXI_RESP_OKAY) begin
            resp_errs++;
            $display("error: %s is %h, expected %h", name, got, AXI_RESP_OKAY);
        end
    endtask

    // ev_o follows the link word by one clock
    always @(negedge rx_clk) begin
        if (run_checks) begin
            check_ev(ev_o, ev_exp);
        end
        ev_exp = expected_ev(rx_data_i, rx_charisk_i, ena_model, aligned_i);
    end

    task automatic send_word(input logic [15:0] data, input logic [1:0] isk);
        @(posedge rx_clk);
        rx_data_i    <= data;
        rx_charisk_i <= isk;
        if (link_model && !isk[0] && data[7:0] == BEACON_SYM) begin
            beacon_model = beacon_model + 1;
        end
    endtask

    task automatic link_idle();
        send_word({8'h00, COMMA_SYM}, 2'b01);
    endtask

    task automatic set_link(input logic up);
        @(posedge rx_clk);
        aligned_i  <= up;
        link_model = up;
        if (!up) begin
            ena_model = 1'b0;
        end
    endtask

    // Mix of plain codes, zeros, commas, beacons and stray K symbols
    task automatic send_random(input int n);
        logic [31:0] r;
        sym_byte_t   lo;
        logic        k;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            k = 1'b0;
            case (r[10:8])
                3'd0: lo = 8'h00;
                3'd1: begin
                    lo = COMMA_SYM;
                    k  = 1'b1;
                end
                3'd2: lo = BEACON_SYM;
                default: begin
                    lo = r[7:0];
                    k  = r[11] & r[12];
                end
            endcase
            send_word({8'h00, lo}, {1'b0, k});
        end
        link_idle();
    endtask

    // Frame on the high lane that is cut after cut_at payload bytes when short
    task automatic send_frame(input sym_byte_t msg, input mmr_data_t payload, input int cut_at);
        send_word({FRAME_START_SYM, COMMA_SYM}, 2'b11);
        send_word({msg, COMMA_SYM}, 2'b01);
        for (int i = 0; i < cut_at; i++) begin
            send_word({payload[31 - 8 * i -: 8], COMMA_SYM}, 2'b01);
        end
        if (cut_at < PAYLOAD_BYTES) begin
            send_word({COMMA_SYM, COMMA_SYM}, 2'b11);
            status_m.frame_abort = 1'b1;
        end
        else begin
            case (msg)
                MSG_DELAY: begin
                    delay_model         = payload;
                    status_m.delay_seen = 1'b1;
                end
                MSG_TOPO: begin
                    topo_model         = payload;
                    status_m.topo_seen = 1'b1;
                end
                default: ;
            endcase
        end
        link_idle();
        link_idle();
    endtask

    task automatic axi_read(input mmr_addr_t addr, output mmr_data_t data);
        @(posedge rx_clk);
        mmr_araddr_i  <= addr;
        mmr_arvalid_i <= 1'b1;
        mmr_rready_i  <= 1'b1;
        @(negedge rx_clk);
        while (!mmr_arready_o) @(negedge rx_clk);
        @(posedge rx_clk);
        mmr_arvalid_i <= 1'b0;
        @(negedge rx_clk);
        while (!mmr_rvalid_o) @(negedge rx_clk);
        data = mmr_rdata_o;
        check_resp("mmr_rresp_o", mmr_rresp_o);
        @(posedge rx_clk);
        mmr_rready_i <= 1'b0;
    endtask

    task automatic axi_write(input mmr_addr_t addr, input mmr_data_t data);
        logic aw_open;
        logic w_open;
        logic aw_hit;
        logic w_hit;
        @(posedge rx_clk);
        mmr_awaddr_i  <= addr;
        mmr_awvalid_i <= 1'b1;
        mmr_wdata_i   <= data;
        mmr_wvalid_i  <= 1'b1;
        mmr_bready_i  <= 1'b1;
        aw_open = 1'b1;
        w_open  = 1'b1;
        while (aw_open || w_open) begin
            @(negedge rx_clk);
            aw_hit = aw_open && mmr_awready_o;
            w_hit  = w_open && mmr_wready_o;
            @(posedge rx_clk);
            if (aw_hit) begin
                mmr_awvalid_i <= 1'b0;
                aw_open = 1'b0;
            end
            if (w_hit) begin
                mmr_wvalid_i <= 1'b0;
                w_open = 1'b0;
            end
        end
        @(negedge rx_clk);
        while (!mmr_bvalid_o) @(negedge rx_clk);
        check_resp("mmr_bresp_o", mmr_bresp_o);
        @(posedge rx_clk);
        mmr_bready_i <= 1'b0;
        // Register takes the write on the B handshake
        case (addr)
            REG_CR:   ena_model = data[0];
            REG_CR_S: ena_model = ena_model | data[0];
            REG_CR_C: ena_model = ena_model & ~data[0];
            REG_TGT_DELAY: begin
                if (data > delay_model) begin
                    tgt_model = data;
                end
            end
            default: ;
        endcase
        if (!link_model) begin
            ena_model = 1'b0;
        end
    endtask

    initial begin
        seed = 14;
        app_rst       <= 1'b1;
        aligned_i     <= 1'b1;
        rx_data_i     <= {8'h00, COMMA_SYM};
        rx_charisk_i  <= 2'b01;
        mmr_araddr_i  <= '0;
        mmr_arvalid_i <= 1'b0;
        mmr_rready_i  <= 1'b0;
        mmr_awaddr_i  <= '0;
        mmr_awvalid_i <= 1'b0;
        mmr_wdata_i   <= '0;
        mmr_wvalid_i  <= 1'b0;
        mmr_bready_i  <= 1'b0;
        repeat (2) @(posedge rx_clk);
        app_rst <= 1'b0;
        run_checks = 1'b1;

        // Out of reset with events disabled
        axi_read(REG_SR, rd_val);
        check_reg("SR", rd_val, expected_sr());
        axi_read(REG_CR, rd_val);
        check_reg("CR", rd_val, mmr_data_t'(ena_model));
        send_random(N_RAND_EV);

        axi_write(REG_CR_S, 32'h1);
        axi_read(REG_CR, rd_val);
        check_reg("CR", rd_val, mmr_data_t'(ena_model));
        send_random(N_RAND_ENA);
        axi_write(REG_CR_C, 32'h1);
        axi_read(REG_CR, rd_val);
        check_reg("CR", rd_val, mmr_data_t'(ena_model));
        send_random(N_RAND_TAIL);

        for (int i = 0; i < N_BEACON; i++) begin
            send_word({8'h00, BEACON_SYM}, 2'b00);
            link_idle();
        end
        axi_read(REG_BEACON_CNT, rd_val);
        check_reg("BEACON_CNT", rd_val, beacon_model);

        // Two full shared-data frames and one cut short
        send_frame(MSG_DELAY, 32'h0001_86A0, PAYLOAD_BYTES);
        send_frame(MSG_TOPO, 32'h5A3C_0F17, PAYLOAD_BYTES);
        axi_read(REG_LINK_DELAY, rd_val);
        check_reg("LINK_DELAY", rd_val, delay_model);
        axi_read(REG_TOPO_ID, rd_val);
        check_reg("TOPO_ID", rd_val, topo_model);
        axi_read(REG_SR, rd_val);
        check_reg("SR", rd_val, expected_sr());
        send_frame(MSG_DELAY, 32'h00FF_0BAD, 2);
        axi_read(REG_LINK_DELAY, rd_val);
        check_reg("LINK_DELAY", rd_val, delay_model);
        axi_read(REG_SR, rd_val);
        check_reg("SR", rd_val, expected_sr());

        axi_write(REG_TGT_DELAY, delay_model - 32'd1);
        axi_read(REG_TGT_DELAY, rd_val);
        check_reg("TGT_DELAY", rd_val, tgt_model);
        axi_write(REG_TGT_DELAY, delay_model + TGT_MARGIN);
        axi_read(REG_TGT_DELAY, rd_val);
        check_reg("TGT_DELAY", rd_val, tgt_model);
        axi_read(REG_DELAY_DIFF, rd_val);
        check_reg("DELAY_DIFF", rd_val, TGT_MARGIN);

        // Link loss clears ev_ena
        axi_write(REG_CR_S, 32'h1);
        // Event code still on the link as it drops
        send_word({8'h00, 8'h5A}, 2'b00);
        set_link(1'b0);
        send_random(N_RAND_DOWN);
        axi_read(REG_SR, rd_val);
        check_reg("SR", rd_val, expected_sr());
        axi_read(REG_CR, rd_val);
        check_reg("CR", rd_val, mmr_data_t'(ena_model));
        set_link(1'b1);
        send_random(N_RAND_DOWN);
        repeat (4) @(posedge rx_clk);

        $display("Done with %0d ev_o errors, %0d register errors, %0d response errors",
                 ev_errs, reg_errs, resp_errs);
        if (ev_errs + reg_errs + resp_errs == 0) begin
            $display(">>> PASS");
        end
        else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
